//--- src/fabric_cfg.svh
// Build-time sizes for the mesh tile north port
// Include wherever lane count, FIFO depth or field widths are needed
`ifndef FABRIC_CFG_SVH
`define FABRIC_CFG_SVH

// ====================
// Lane configuration
// ====================

// Neighbor lanes feeding the port
`define FABRIC_NUM_CLIENTS 4

// Entries per lane FIFO, keep a power of two
`define FABRIC_FIFO_DEPTH 4

// ====================
// Transaction fields
// ====================

// One mesh coordinate, 8 by 8 mesh
`define FABRIC_COORD_W 3

// Data carried with each request
`define FABRIC_PAYLOAD_W 16

`endif

//--- src/fabric_pkg.sv
// Shared types for the tile north port
// Import into any block that handles coordinates, lanes or transactions
`include "fabric_cfg.svh"

package fabric_pkg;

    // ====================
    // Field types
    // ====================
    typedef logic [`FABRIC_COORD_W-1:0]     t_coord;      // Mesh X or Y
    typedef logic [`FABRIC_PAYLOAD_W-1:0]   t_payload;    // Opaque data
    typedef logic [`FABRIC_NUM_CLIENTS-1:0] t_client_vec; // One bit per lane

    // Output port the next tile will pick for a transaction
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_cardinal;

    // ====================
    // Transactions
    // ====================

    // Raw request as offered by a neighbor lane
    typedef struct packed {
        t_coord   dest_x;
        t_coord   dest_y;
        t_payload payload;
    } t_tile_req;

    // Request after decode, with the next hop's arbitration FIFO
    typedef struct packed {
        t_coord    dest_x;
        t_coord    dest_y;
        t_cardinal next_tile_fifo_arb_id; // Which FIFO in the north neighbor
        t_payload  payload;
    } t_tile_trans;

endpackage

//--- src/route_decode.sv
// Decode stage of the north port
// Works out the port the north neighbor will use under XY routing
`timescale 1ns/100ps

module route_decode
    import fabric_pkg::*;
(
    input  t_coord      tile_x, // This tile's position
    input  t_coord      tile_y,
    input  t_tile_req   req,    // Request from one lane
    output t_tile_trans trans   // Same request with next hop cardinal
);

    // The request leaves north so the next tile sits one row up
    t_coord    next_x;
    t_coord    next_y;
    t_cardinal next_dir;

    assign next_x = tile_x;                 // Same column
    assign next_y = tile_y + t_coord'(1);   // One row up

    // ====================
    // XY routing decision
    // ====================
    // X is resolved first, then Y, then the packet has arrived
    always_comb begin
        if (req.dest_x > next_x) begin
            next_dir = EAST;
        end else if (req.dest_x < next_x) begin
            next_dir = WEST;
        end else if (req.dest_y > next_y) begin
            next_dir = NORTH;                // Still climbing
        end else if (req.dest_y < next_y) begin
            next_dir = SOUTH;                // Overshoot in Y
        end else begin
            next_dir = LOCAL;                // Next tile is the target
        end
    end

    // Destination and data pass through untouched
    always_comb begin
        trans.dest_x                = req.dest_x;
        trans.dest_y                = req.dest_y;
        trans.next_tile_fifo_arb_id = next_dir;
        trans.payload               = req.payload;
    end

endmodule

//--- src/fifo.sv
// Synchronous FIFO with first-word fall-through
// Head is visible on pop_data whenever empty is low
`timescale 1ns/100ps

module fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4   // Power of two, at least 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,      // Write strobe
    input  logic [DATA_WIDTH-1:0] push_data,
    input  logic                  pop,       // Remove head
    output logic [DATA_WIDTH-1:0] pop_data,  // Current head
    output logic                  full,
    output logic                  empty
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem_q [FIFO_DEPTH]; // Storage array
    logic [ADDR_W-1:0]     wr_ptr_q;
    logic [ADDR_W-1:0]     rd_ptr_q;
    logic [CNT_W-1:0]      count_q;            // Occupancy
    logic                  do_push;
    logic                  do_pop;

    assign full    = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty   = (count_q == '0);
    assign do_push = push && !full;   // Push into a full FIFO is dropped
    assign do_pop  = pop && !empty;

    // ====================
    // Pointers and count
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + ADDR_W'(1); // Wraps at depth
            if (do_pop)  rd_ptr_q <= rd_ptr_q + ADDR_W'(1);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;          // Both or neither
            endcase
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data;
        end
    end

    assign pop_data = mem_q[rd_ptr_q]; // Fall-through read

endmodule

//--- src/rr_arbiter.sv
// Round-robin arbiter with a one-hot grant
// Grant is combinational, the priority pointer moves past each winner
`timescale 1ns/100ps

module rr_arbiter #(
    parameter int NUM_CLIENTS = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [NUM_CLIENTS-1:0] valid_candidate, // Requesting lanes
    output logic [NUM_CLIENTS-1:0] winner_dec_id    // One-hot, zero if idle
);

    localparam int PTR_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

    logic [PTR_W-1:0] ptr_q;    // Lane with top priority
    logic [PTR_W-1:0] win_idx;  // Index of granted lane
    logic             found;

    // ====================
    // Grant search
    // ====================
    // Scan from the pointer and wrap, first candidate wins
    always_comb begin
        int idx;
        winner_dec_id = '0;
        win_idx       = ptr_q;
        found         = 1'b0;
        for (int off = 0; off < NUM_CLIENTS; off++) begin
            idx = (int'(ptr_q) + off) % NUM_CLIENTS;
            if (!found && valid_candidate[idx]) begin
                found              = 1'b1;
                win_idx            = PTR_W'(idx);
                winner_dec_id[idx] = 1'b1;
            end
        end
    end

    // Pointer moves to the lane after the winner
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q <= '0;                             // Lane 0 first
        end else if (found) begin
            if (win_idx == PTR_W'(NUM_CLIENTS - 1))
                ptr_q <= '0;                         // Wrap
            else
                ptr_q <= win_idx + PTR_W'(1);
        end
    end

endmodule

//--- src/fifo_arb.sv
// Execute stage of the north port
// Buffers each lane, picks one ready head per cycle and muxes it out
`timescale 1ns/100ps
`include "fabric_cfg.svh"

module fifo_arb
    import fabric_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // ====================
    // Lanes from neighbors
    // ====================
    input  t_client_vec valid_alloc_req,                      // Push strobes
    input  t_tile_trans alloc_req [`FABRIC_NUM_CLIENTS],      // Decoded requests
    output t_client_vec out_ready_fifo,                       // Not full
    // ====================
    // Toward north tile
    // ====================
    output t_tile_trans winner_req,
    output logic        winner_req_valid,
    input  logic        in_ready_north,  // Ready of each FIFO in the north tile
    input  logic        in_ready_east,
    input  logic        in_ready_south,
    input  logic        in_ready_west,
    input  logic        in_ready_local
);

    t_tile_trans dout_fifo [`FABRIC_NUM_CLIENTS]; // Lane heads
    t_client_vec full;
    t_client_vec empty;
    t_client_vec valid_candidate;
    t_client_vec winner_dec_id;                   // Grant, also the pop vector

    assign out_ready_fifo = ~full;

    // One FIFO per lane
    for (genvar i = 0; i < `FABRIC_NUM_CLIENTS; i++) begin : gen_lane
        fifo #(
            .DATA_WIDTH ($bits(t_tile_trans)),
            .FIFO_DEPTH (`FABRIC_FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (valid_alloc_req[i]),
            .push_data (alloc_req[i]),
            .pop       (winner_dec_id[i]),    // Popped when granted
            .pop_data  (dout_fifo[i]),
            .full      (full[i]),
            .empty     (empty[i])
        );
    end

    // Candidate needs a head and a ready target FIFO for its cardinal
    always_comb begin
        logic target_ready;
        valid_candidate = '0;
        for (int i = 0; i < `FABRIC_NUM_CLIENTS; i++) begin
            case (dout_fifo[i].next_tile_fifo_arb_id)
                NORTH:   target_ready = in_ready_north;
                EAST:    target_ready = in_ready_east;
                SOUTH:   target_ready = in_ready_south;
                WEST:    target_ready = in_ready_west;
                LOCAL:   target_ready = in_ready_local;
                default: target_ready = 1'b0;        // Unused encodings
            endcase
            valid_candidate[i] = !empty[i] && target_ready;
        end
    end

    rr_arbiter #(
        .NUM_CLIENTS (`FABRIC_NUM_CLIENTS)
    ) u_rr_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .valid_candidate (valid_candidate),
        .winner_dec_id   (winner_dec_id)
    );

    // Result mux, grant is one-hot
    always_comb begin
        winner_req = '0;
        for (int i = 0; i < `FABRIC_NUM_CLIENTS; i++) begin
            if (winner_dec_id[i]) winner_req = dout_fifo[i];
        end
    end

    assign winner_req_valid = |winner_dec_id;

endmodule

//--- src/tile_north_port.sv
// North output port of one mesh tile
// Decodes four lanes with XY routing and arbitrates them toward the north tile
`timescale 1ns/100ps
`include "fabric_cfg.svh"

module tile_north_port
    import fabric_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  t_coord      tile_x,                          // Position straps
    input  t_coord      tile_y,
    input  t_client_vec valid_alloc_req,
    input  t_tile_req   alloc_req [`FABRIC_NUM_CLIENTS], // Raw lane requests
    output t_client_vec out_ready_fifo,
    output t_tile_trans winner_req,
    output logic        winner_req_valid,
    input  logic        in_ready_north,
    input  logic        in_ready_east,
    input  logic        in_ready_south,
    input  logic        in_ready_west,
    input  logic        in_ready_local
);

    t_tile_trans dec_trans [`FABRIC_NUM_CLIENTS]; // Decode to execute

    // Decode stage, one per lane
    for (genvar i = 0; i < `FABRIC_NUM_CLIENTS; i++) begin : gen_decode
        route_decode u_route_decode (
            .tile_x (tile_x),
            .tile_y (tile_y),
            .req    (alloc_req[i]),
            .trans  (dec_trans[i])
        );
    end

    // Execute and result stages
    fifo_arb u_fifo_arb (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_alloc_req  (valid_alloc_req),
        .alloc_req        (dec_trans),
        .out_ready_fifo   (out_ready_fifo),
        .winner_req       (winner_req),
        .winner_req_valid (winner_req_valid),
        .in_ready_north   (in_ready_north),
        .in_ready_east    (in_ready_east),
        .in_ready_south   (in_ready_south),
        .in_ready_west    (in_ready_west),
        .in_ready_local   (in_ready_local)
    );

endmodule

//--- dv/tile_north_port_assert.sv
// Concurrent checks on the execute stage of the north port
// Bound into fifo_arb, failures show up as assertion errors
`timescale 1ns/100ps

module tile_north_port_assert
    import fabric_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input t_client_vec valid_alloc_req,  // Push strobes
    input t_client_vec full,             // Lane FIFO full flags
    input t_client_vec valid_candidate,
    input t_client_vec winner_dec_id,    // Grant, one-hot or zero
    input logic        winner_req_valid
);

    // Lane pushes only while its FIFO has room
    push_into_full: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_alloc_req & full) == '0)
        else $error("push into a full lane FIFO");

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(winner_dec_id))
        else $error("more than one grant bit set");

    // Grant only where a head waits on a ready target
    grant_is_candidate: assert property (@(posedge clk) disable iff (!rst_n)
        (winner_dec_id & ~valid_candidate) == '0)
        else $error("grant to a lane that is not a candidate");

    // From the second reset edge on the port stays quiet
    idle_in_reset: assert property (@(posedge clk)
        (!rst_n && !$past(rst_n)) |-> !winner_req_valid)
        else $error("winner valid during reset");

endmodule

bind fifo_arb tile_north_port_assert u_tile_north_port_assert (
    .clk              (clk),
    .rst_n            (rst_n),
    .valid_alloc_req  (valid_alloc_req),
    .full             (full),
    .valid_candidate  (valid_candidate),
    .winner_dec_id    (winner_dec_id),
    .winner_req_valid (winner_req_valid)
);

//--- dv/tile_north_port_tb.sv
// Self-checking testbench for the tile north port
// Drives seeded random lanes and checks every rising edge against a queue model
`timescale 1ns/100ps
`include "fabric_cfg.svh"

module tile_north_port_tb
    import fabric_pkg::*;
();

    localparam int NL           = `FABRIC_NUM_CLIENTS;
    localparam int DEPTH        = `FABRIC_FIFO_DEPTH;
    localparam int CLK_PERIOD   = 20;
    localparam int RST_CYCLES   = 16;
    localparam int RR_CYCLES    = DEPTH + 1 + NL * DEPTH; // Fill, full check, drain
    localparam int BP_CYCLES    = 5 * 45;                 // 30 held and 15 free per cardinal
    localparam int RAND_CYCLES  = 400;
    localparam int PARK_CYCLES  = NL * DEPTH + 2;         // Drain plus one lone grant
    localparam int TOTAL_CYCLES = 2 * RST_CYCLES + 2 * RR_CYCLES + BP_CYCLES + RAND_CYCLES
                                  + PARK_CYCLES;

    logic        clk;
    logic        rst_n;
    t_coord      tile_x;
    t_coord      tile_y;
    t_client_vec valid_alloc_req;
    t_tile_req   alloc_req [NL];
    t_client_vec out_ready_fifo;
    t_tile_trans winner_req;
    logic        winner_req_valid;
    logic [4:0]  in_ready;             // One bit per cardinal with NORTH in bit 0

    // ====================
    // Staged stimulus
    // ====================
    logic        rst_next;             // Applied at the next falling edge
    t_client_vec push_next;
    t_tile_req   req_next [NL];
    logic [4:0]  ready_next;
    t_coord      x_next;
    t_coord      y_next;

    // Model state
    t_tile_trans lane_q [NL][$];       // Decoded entries per lane
    int          rr_ptr;
    bit          model_ok;             // Known state after a reset edge
    int          held_dir;             // Cardinal held low or -1
    int          progress;             // Grants seen while a level is held
    int          dir_seen [5];         // Winners per cardinal
    t_client_vec seen_ready;           // DUT outputs at the last rising edge
    logic        seen_valid;
    t_tile_trans seen_win;
    int          missing;

    tile_north_port u_tile_north_port (
        .clk              (clk),
        .rst_n            (rst_n),
        .tile_x           (tile_x),
        .tile_y           (tile_y),
        .valid_alloc_req  (valid_alloc_req),
        .alloc_req        (alloc_req),
        .out_ready_fifo   (out_ready_fifo),
        .winner_req       (winner_req),
        .winner_req_valid (winner_req_valid),
        .in_ready_north   (in_ready[0]),
        .in_ready_east    (in_ready[1]),
        .in_ready_south   (in_ready[2]),
        .in_ready_west    (in_ready[3]),
        .in_ready_local   (in_ready[4])
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog sized from the phase lengths
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD + 1000);
        $display("Timeout: run did not finish within %0d cycles", TOTAL_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // XY rule seen from the tile one row up
    function automatic t_cardinal xy_dir(t_coord dx, t_coord dy, t_coord tx, t_coord ty);
        int nx;
        int ny;
        nx = int'(tx);
        ny = int'(ty) + 1;
        if (int'(dx) > nx) return EAST;
        if (int'(dx) < nx) return WEST;
        if (int'(dy) > ny) return NORTH;
        if (int'(dy) < ny) return SOUTH;
        return LOCAL;
    endfunction

    // ====================
    // One clock of stimulus, prediction and check
    // ====================
    task automatic step_cycle(input string name);
        t_client_vec exp_ready;
        t_client_vec cand;
        t_client_vec pushed;
        t_tile_trans exp_win;
        t_tile_trans dec;
        int          gnt;
        int          idx;
        @(negedge clk);
        for (int i = 0; i < NL; i++) exp_ready[i] = (lane_q[i].size() < DEPTH);
        rst_n           = rst_next;
        in_ready        = ready_next;
        tile_x          = x_next;
        tile_y          = y_next;
        valid_alloc_req = push_next & exp_ready; // Only push into lanes with room
        pushed          = valid_alloc_req;
        for (int i = 0; i < NL; i++) alloc_req[i] = req_next[i];
        exp_win = '0;
        gnt     = -1;
        for (int i = 0; i < NL; i++) begin
            cand[i] = 1'b0;
            if (lane_q[i].size() != 0) cand[i] = in_ready[lane_q[i][0].next_tile_fifo_arb_id];
        end
        for (int off = 0; off < NL; off++) begin
            idx = (rr_ptr + off) % NL;
            if (gnt < 0 && cand[idx]) gnt = idx;   // First candidate from the pointer
        end
        if (gnt >= 0) exp_win = lane_q[gnt][0];
        @(posedge clk);
        seen_ready = out_ready_fifo;
        seen_valid = winner_req_valid;
        seen_win   = winner_req;
        if (model_ok) begin
            check_value({name, " out_ready"}, 32'(exp_ready), 32'(seen_ready));
            check_value({name, " valid"}, 32'(gnt >= 0), 32'(seen_valid));
            if (gnt >= 0) begin
                check_value({name, " decode"}, int'(exp_win.next_tile_fifo_arb_id),
                            int'(seen_win.next_tile_fifo_arb_id));
                check_value({name, " winner"}, {7'd0, exp_win}, {7'd0, seen_win});
                dir_seen[int'(seen_win.next_tile_fifo_arb_id)]++;
                if (held_dir >= 0) begin
                    check_value({name, " held"}, 0,
                                32'(int'(seen_win.next_tile_fifo_arb_id) == held_dir));
                    progress++;
                end
            end
        end
        // Pops reach the model before the new pushes land
        if (!rst_n) begin
            for (int i = 0; i < NL; i++) lane_q[i].delete();
            rr_ptr   = 0;
            model_ok = 1'b1;
        end else begin
            if (gnt >= 0) begin
                void'(lane_q[gnt].pop_front());
                rr_ptr = (gnt + 1) % NL;
            end
            for (int i = 0; i < NL; i++) begin
                if (pushed[i]) begin
                    dec.dest_x                = req_next[i].dest_x;
                    dec.dest_y                = req_next[i].dest_y;
                    dec.next_tile_fifo_arb_id = xy_dir(req_next[i].dest_x,
                                                       req_next[i].dest_y, tile_x, tile_y);
                    dec.payload               = req_next[i].payload;
                    lane_q[i].push_back(dec);
                end
            end
        end
    endtask

    // Random request that now and then targets the next tile itself
    function automatic t_tile_req random_req();
        t_tile_req r;
        r.dest_x  = t_coord'($urandom_range(0, 7));
        r.dest_y  = t_coord'($urandom_range(0, 7));
        r.payload = t_payload'($urandom);
        if ($urandom_range(0, 7) == 0) begin
            r.dest_x = x_next;
            r.dest_y = y_next + t_coord'(1);
        end
        return r;
    endfunction

    task automatic random_pushes();
        for (int i = 0; i < NL; i++) begin
            push_next[i] = ($urandom_range(0, 99) < 50);
            req_next[i]  = random_req();
        end
    endtask

    task automatic new_straps();
        x_next = t_coord'($urandom_range(0, 7));
        y_next = t_coord'($urandom_range(0, 6));   // Keep the north neighbor on the mesh
    endtask

    task automatic apply_reset(input string name);
        rst_next  = 1'b0;
        push_next = '0;
        for (int k = 0; k < RST_CYCLES; k++) step_cycle(name);
        check_value({name, " ready"}, 32'((1 << NL) - 1), 32'(seen_ready));
        check_value({name, " valid"}, 0, 32'(seen_valid));
        rst_next = 1'b1;
    endtask

    // Fill every lane with readies low, then drain with all readies high
    task automatic rotate_lanes(input string name);
        ready_next = '0;
        push_next  = '1;
        for (int k = 0; k < DEPTH; k++) begin
            for (int i = 0; i < NL; i++) begin
                req_next[i]                = random_req();
                req_next[i].payload[15:14] = 2'(i);   // Lane tag
            end
            step_cycle(name);
        end
        push_next = '0;
        step_cycle(name);
        check_value({name, " full"}, 0, 32'(seen_ready));
        ready_next = '1;
        for (int k = 0; k < NL * DEPTH; k++) begin
            step_cycle(name);
            check_value({name, " lane"}, 32'(k % NL), 32'(seen_win.payload[15:14]));
        end
    endtask

    // Empty all lanes, then let a lone lane 1 entry win so the pointer leaves lane 0
    task automatic park_pointer(input string name);
        int busy;
        ready_next = '1;
        push_next  = '0;
        busy       = 1;
        while (busy != 0) begin
            step_cycle(name);
            busy = 0;
            for (int i = 0; i < NL; i++) busy += lane_q[i].size();
        end
        req_next[1]  = random_req();
        push_next[1] = 1'b1;
        step_cycle(name);
        push_next = '0;
        step_cycle(name);
        check_value({name, " lone grant"}, 1, 32'(seen_valid));
    endtask

    task automatic hold_one_ready(input string name);
        for (int d = 0; d < 5; d++) begin
            new_straps();
            held_dir = d;
            progress = 0;
            for (int k = 0; k < 30; k++) begin
                ready_next = 5'h1f & ~(5'(1) << d);
                random_pushes();
                step_cycle(name);
            end
            check_value({name, " progress"}, 1, 32'(progress > 0));
            held_dir   = -1;
            ready_next = 5'h1f;            // Held heads drain now
            for (int k = 0; k < 15; k++) begin
                random_pushes();
                step_cycle(name);
            end
        end
    endtask

    // Ready levels drop rarely and recover slowly so lanes back up
    task automatic random_traffic(input string name);
        for (int k = 0; k < RAND_CYCLES; k++) begin
            if (k % 100 == 0) new_straps();
            for (int d = 0; d < 5; d++) begin
                if (ready_next[d] && $urandom_range(0, 11) == 0) begin
                    ready_next[d] = 1'b0;
                end else if (!ready_next[d] && $urandom_range(0, 5) == 0) begin
                    ready_next[d] = 1'b1;
                end
            end
            random_pushes();
            step_cycle(name);
        end
    endtask

    initial begin
        void'($urandom(32'ha86e_a6c1));
        rst_n           = 1'b0;
        tile_x          = '0;
        tile_y          = '0;
        valid_alloc_req = '0;
        in_ready        = '0;
        for (int i = 0; i < NL; i++) alloc_req[i] = '0;
        rst_next   = 1'b0;
        push_next  = '0;
        ready_next = '0;
        for (int i = 0; i < NL; i++) req_next[i] = '0;
        for (int d = 0; d < 5; d++) dir_seen[d] = 0;
        model_ok = 1'b0;
        rr_ptr   = 0;
        held_dir = -1;
        progress = 0;
        new_straps();
        apply_reset("reset");
        rotate_lanes("round_robin");
        hold_one_ready("backpressure");
        random_traffic("random");
        park_pointer("park");
        apply_reset("reset_mid");
        rotate_lanes("round_robin_after_reset");
        missing = 0;
        for (int d = 0; d < 5; d++) if (dir_seen[d] == 0) missing++;
        if (missing != 0) begin
            $display("Decode coverage: %0d cardinals never reached the output", missing);
            $display("TEST FAIL");
            $fatal(1, "coverage hole");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- filelist.f
+incdir+src
src/fabric_pkg.sv
src/route_decode.sv
src/fifo.sv
src/rr_arbiter.sv
src/fifo_arb.sv
src/tile_north_port.sv
dv/tile_north_port_assert.sv
dv/tile_north_port_tb.sv

//--- Makefile
# Verilator build and run of the tile north port testbench
TOOL     ?= verilator
FLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP      ?= tile_north_port_tb
FILELIST ?= filelist.f
BUILD    ?= obj_dir
LOG      ?= sim.log
FAIL_MSG  = TEST FAIL
PASS_MSG  = TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation stopped without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
